/* hw/accum_merge.sv */
`timescale 1ns/100ps
`include "fp8_acc_settings.svh"

module accum_merge (
	input  fp8_acc_pkg::sum_mant_t  sum,
	input  fp8_acc_pkg::exp_t       big_exp,
	input  fp8_acc_pkg::fp_fmt_e    fmt,
	input  fp8_acc_pkg::exp_t       shared_exp,
	input  fp8_acc_pkg::acc_word_t  acc,
	output fp8_acc_pkg::wide_mant_t merged_mag,
	output fp8_acc_pkg::exp_t       merged_exp,
	output logic                    merged_sign,
	output logic                    acc_kept
);

	import fp8_acc_pkg::*;

	localparam int SUM_W  = $bits(sum_mant_t);
	localparam int WIDE_W = $bits(wide_mant_t);
	localparam int PAD_W  = WIDE_W - SUM_W;

	exp_t         fmt_bias;
	partial_sum_t psum;
	logic         acc_hidden;
	sum_mant_t    acc_abs;
	sum_mant_t    acc_op;
	logic [`EXP_W:0] exp_diff; // Accumulator exponent minus sum exponent, signed
	logic [`EXP_W:0] neg_diff;
	wide_mant_t   sum_ext;
	wide_mant_t   acc_ext;
	wide_mant_t   total;

	always_comb begin
		case (fmt)
			FMT_E4M3: fmt_bias = exp_t'(`BIAS_E4M3);
			FMT_E3M2: fmt_bias = exp_t'(`BIAS_E3M2);
			FMT_E2M3: fmt_bias = exp_t'(`BIAS_E2M3);
			default:  fmt_bias = exp_t'(`BIAS_E5M2);
		endcase
	end

	// Into FP32 range with the shared scale folded in, wraps at 256
	assign psum.exp  = big_exp + fmt_bias + shared_exp - exp_t'(`FP32_BIAS);
	assign psum.mant = sum;
	assign psum.sign = sum[SUM_W-1];

	// Accumulator as a signed operand at the same scale as the sum
	assign acc_hidden = (acc.exp != '0);
	assign acc_abs    = {1'b0, acc_hidden, acc.mant, 3'b000};
	assign acc_op     = acc.sign ? -acc_abs : acc_abs;

	assign exp_diff = {1'b0, acc.exp} - {1'b0, psum.exp};
	assign neg_diff = -exp_diff;

	always_comb begin
		acc_kept    = 1'b0;
		sum_ext     = '0;
		acc_ext     = '0;
		total       = '0;
		merged_mag  = '0;
		merged_exp  = '0;
		merged_sign = 1'b0;

		if (!exp_diff[`EXP_W] && (exp_diff[`EXP_W-1:0] < `ACC_AHEAD_LIM)) begin
			// Sum stays at the bottom, accumulator moves up
			sum_ext = {{PAD_W{psum.sign}}, psum.mant};
			acc_ext = {{PAD_W{acc_op[SUM_W-1]}}, acc_op} << exp_diff[`EXP_W-1:0];
			total   = sum_ext + acc_ext;
			merged_mag  = total[WIDE_W-1] ? -total : total;
			merged_exp  = acc.exp;
			merged_sign = total[WIDE_W-1];
		end else if (!exp_diff[`EXP_W]) begin
			acc_kept = 1'b1; // Sum falls below the accumulator's LSB
		end else if (neg_diff[`EXP_W-1:0] < `SUM_AHEAD_LIM) begin
			// Sum sits at the top, accumulator slides down with its sign
			sum_ext = {psum.mant, {PAD_W{1'b0}}};
			acc_ext = $signed({acc_op, {PAD_W{1'b0}}}) >>> neg_diff[`EXP_W-1:0];
			total   = sum_ext + acc_ext;
			merged_mag  = total[WIDE_W-1] ? -total : total;
			merged_exp  = psum.exp;
			merged_sign = total[WIDE_W-1];
		end else begin
			// Accumulator vanishes
			merged_mag  = psum.sign ? {-psum.mant, {PAD_W{1'b0}}} : {psum.mant, {PAD_W{1'b0}}};
			merged_exp  = psum.exp;
			merged_sign = psum.sign;
		end
	end

endmodule

/* hw/fp8_acc_pkg.sv */
`include "fp8_acc_settings.svh"

package fp8_acc_pkg;

	typedef logic [`MANT_IN_W-1:0]      mant_in_t;
	typedef logic [`EXP_IN_W-1:0]       exp_in_t;
	typedef logic [`EXP_W-1:0]          exp_t;       // Also used for exponent differences
	typedef logic [`MANT_IN_W+8:0]      lane_mant_t; // Zero MSB, mantissa, 8 guard zeros
	typedef logic [`MANT_OUT_W+4:0]     sum_mant_t;  // Lane width plus two bits of growth
	typedef logic [2*`MANT_OUT_W+6:0]   wide_mant_t;
	typedef logic [`MANT_OUT_W-1:0]     mant_out_t;

	typedef enum logic [1:0] {
		FMT_E2M3 = 2'b00,
		FMT_E3M2 = 2'b01,
		FMT_E4M3 = 2'b10,
		FMT_E5M2 = 2'b11
	} fp_fmt_e;

	// One product lane, magnitude plus sign
	typedef struct packed {
		logic     sign;
		exp_in_t  exp;
		mant_in_t mant;
	} product_t;

	typedef struct packed {
		logic      sign;
		exp_t      exp;
		mant_out_t mant;
	} acc_word_t;

	// Rebiased four-lane sum, mantissa in two's complement
	typedef struct packed {
		logic      sign;
		exp_t      exp;
		sum_mant_t mant;
	} partial_sum_t;

endpackage

/* hw/fp8_dot_acc.sv */
`timescale 1ns/100ps
`include "fp8_acc_settings.svh"

module fp8_dot_acc (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   valid_in,
	input  logic                   acc_clear,
	input  fp8_acc_pkg::product_t  products [`LANES],
	input  fp8_acc_pkg::fp_fmt_e   fmt,
	input  fp8_acc_pkg::exp_t      shared_exp,
	output fp8_acc_pkg::acc_word_t result
);

	import fp8_acc_pkg::*;

	lane_mant_t lane_mant [`LANES];
	exp_t       lane_shift [`LANES];
	exp_t       big_exp;
	sum_mant_t  sum;
	wide_mant_t merged_mag;
	exp_t       merged_exp;
	logic       merged_sign;
	logic       acc_kept;
	mant_out_t  norm_mant;
	exp_t       norm_exp;
	acc_word_t  acc_next;
	acc_word_t  acc_reg;

	operand_align u_align (
		.products   (products),
		.fmt        (fmt),
		.lane_mant  (lane_mant),
		.lane_shift (lane_shift),
		.big_exp    (big_exp)
	);

	product_sum u_sum (
		.lane_mant  (lane_mant),
		.lane_shift (lane_shift),
		.sum        (sum)
	);

	accum_merge u_merge (
		.sum         (sum),
		.big_exp     (big_exp),
		.fmt         (fmt),
		.shared_exp  (shared_exp),
		.acc         (acc_reg),
		.merged_mag  (merged_mag),
		.merged_exp  (merged_exp),
		.merged_sign (merged_sign),
		.acc_kept    (acc_kept)
	);

	normalize u_norm (
		.merged_mag (merged_mag),
		.merged_exp (merged_exp),
		.norm_mant  (norm_mant),
		.norm_exp   (norm_exp)
	);

	always_comb begin
		if (acc_kept) begin
			acc_next = acc_reg; // Products too small to register
		end else begin
			acc_next.sign = merged_sign;
			acc_next.exp  = norm_exp;
			acc_next.mant = norm_mant;
		end
	end

	// Clear wins over a valid product set in the same cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			acc_reg <= '0;
		end else if (acc_clear) begin
			acc_reg <= '0;
		end else if (valid_in) begin
			acc_reg <= acc_next;
		end
	end

	assign result = acc_reg;

endmodule

/* hw/normalize.sv */
`timescale 1ns/100ps
`include "fp8_acc_settings.svh"

module normalize (
	input  fp8_acc_pkg::wide_mant_t merged_mag,
	input  fp8_acc_pkg::exp_t       merged_exp,
	output fp8_acc_pkg::mant_out_t  norm_mant,
	output fp8_acc_pkg::exp_t       norm_exp
);

	import fp8_acc_pkg::*;

	localparam int MAG_W = $bits(wide_mant_t);
	localparam int LZ_W  = $clog2(MAG_W);

	logic [LZ_W-1:0] lead_zeros;
	wide_mant_t      shifted;

	// Scan upwards, the highest set bit is the last one to write
	always_comb begin
		lead_zeros = '0;
		for (int i = 0; i < MAG_W; i++) begin
			if (merged_mag[i]) begin
				lead_zeros = LZ_W'(MAG_W - 1 - i);
			end
		end
	end

	// One extra shift drops the hidden bit
	assign shifted   = merged_mag << (lead_zeros + 1);
	assign norm_mant = shifted[MAG_W-1 -: `MANT_OUT_W];

	// Binary point sits one below the magnitude MSB
	assign norm_exp = merged_exp - exp_t'(lead_zeros) + exp_t'(1);

endmodule

/* hw/operand_align.sv */
`timescale 1ns/100ps
`include "fp8_acc_settings.svh"

module operand_align (
	input  fp8_acc_pkg::product_t   products [`LANES],
	input  fp8_acc_pkg::fp_fmt_e    fmt,
	output fp8_acc_pkg::lane_mant_t lane_mant [`LANES],
	output fp8_acc_pkg::exp_t       lane_shift [`LANES],
	output fp8_acc_pkg::exp_t       big_exp
);

	import fp8_acc_pkg::*;

	localparam int GUARD_W = $bits(lane_mant_t) - `MANT_IN_W - 1;

	mant_in_t   mant_pre [`LANES];
	exp_t       lane_exp [`LANES];
	lane_mant_t lane_abs [`LANES];

	// E5M2 carries two fewer mantissa bits, move them up to line up with the others
	always_comb begin
		for (int i = 0; i < `LANES; i++) begin
			if (fmt == FMT_E5M2) begin
				mant_pre[i] = products[i].mant << `E5M2_PRESHIFT;
			end else begin
				mant_pre[i] = products[i].mant;
			end
			lane_exp[i] = {{(`EXP_W-`EXP_IN_W){1'b0}}, products[i].exp};
		end
	end

	// Largest exponent, first lane wins on a tie
	always_comb begin
		big_exp = lane_exp[0];
		for (int i = 1; i < `LANES; i++) begin
			if (lane_exp[i] > big_exp) begin
				big_exp = lane_exp[i];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < `LANES; i++) begin
			lane_shift[i] = big_exp - lane_exp[i]; // Never negative
			lane_abs[i] = {1'b0, mant_pre[i], {GUARD_W{1'b0}}};

			// Two's complement from here on
			if (products[i].sign) begin
				lane_mant[i] = -lane_abs[i];
			end else begin
				lane_mant[i] = lane_abs[i];
			end
		end
	end

endmodule

/* hw/product_sum.sv */
`timescale 1ns/100ps
`include "fp8_acc_settings.svh"

module product_sum (
	input  fp8_acc_pkg::lane_mant_t lane_mant [`LANES],
	input  fp8_acc_pkg::exp_t       lane_shift [`LANES],
	output fp8_acc_pkg::sum_mant_t  sum
);

	import fp8_acc_pkg::*;

	localparam int LANE_W = $bits(lane_mant_t);
	localparam int GROW_W = $bits(sum_mant_t) - LANE_W;

	lane_mant_t shifted [`LANES];

	always_comb begin
		sum_mant_t total;

		total = '0;
		for (int i = 0; i < `LANES; i++) begin
			// Sign bits fill in from the top
			shifted[i] = $signed(lane_mant[i]) >>> lane_shift[i];
			total = total + {{GROW_W{shifted[i][LANE_W-1]}}, shifted[i]};
		end
		sum = total;
	end

endmodule

/* include/fp8_acc_settings.svh */
`ifndef FP8_ACC_SETTINGS_SVH
`define FP8_ACC_SETTINGS_SVH

`define MANT_IN_W      10   // Product mantissa
`define EXP_IN_W       6    // Product exponent
`define MANT_OUT_W     16   // Stored mantissa, hidden bit excluded
`define EXP_W          8    // FP32-range exponent
`define LANES          4

// Added to the largest product exponent, one per FP8 format
`define BIAS_E4M3      118
`define BIAS_E3M2      128
`define BIAS_E2M3      126
`define BIAS_E5M2      100

`define FP32_BIAS      127
`define E5M2_PRESHIFT  4

// Exponent gaps beyond which one operand no longer reaches the other
`define ACC_AHEAD_LIM  17
`define SUM_AHEAD_LIM  39

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the FP8 dot-product accumulator testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log \
	&& verilator --binary --timing -Wno-fatal -f vlog.f \
		--top-module tb_fp8_dot_acc -Mdir obj_dir -o sim_tb \
	&& ./obj_dir/sim_tb | tee sim.log \
	&& grep -qx ">>> PASS" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* verif/acc_checker.sv */
`timescale 1ns/100ps
`include "fp8_acc_settings.svh"

module acc_checker #(
	parameter int NUM_TESTS = 8
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   valid_in,
	input  logic                   acc_clear,
	input  fp8_acc_pkg::product_t  products [`LANES],
	input  fp8_acc_pkg::fp_fmt_e   fmt,
	input  fp8_acc_pkg::exp_t      shared_exp,
	input  fp8_acc_pkg::acc_word_t result,
	input  int                     test_id,
	output int                     check_count,
	output int                     error_count
);

	import fp8_acc_pkg::*;

	localparam int     WIDE_W   = $bits(wide_mant_t);
	localparam int     PAD_W    = WIDE_W - $bits(sum_mant_t);
	localparam longint MAG_MASK = (longint'(1) << WIDE_W) - 1;

	acc_word_t model_acc;
	logic      checking; // Set one edge after reset releases
	int        cur_id;
	int        test_checks;
	int        test_errors;

	function automatic string test_name(int id);
		case (id)
			0: return "reset_clear";
			1: return "hold";
			2: return "acc_e2m3";
			3: return "acc_e3m2";
			4: return "acc_e4m3";
			5: return "acc_e5m2";
			6: return "acc_dominant";
			7: return "sum_dominant";
			default: return "idle";
		endcase
	endfunction

	function automatic int format_bias(fp_fmt_e f);
		case (f)
			FMT_E2M3: return `BIAS_E2M3;
			FMT_E3M2: return `BIAS_E3M2;
			FMT_E4M3: return `BIAS_E4M3;
			default:  return `BIAS_E5M2;
		endcase
	endfunction

	// Next accumulator word from the current port values, all in plain integers
	function automatic acc_word_t next_word(acc_word_t acc);
		int        big;
		int        mant;
		int        sum_exp;
		int        merged_exp;
		int        diff;
		int        lz;
		logic      neg;
		logic      found;
		longint    lane;
		longint    sum;
		longint    acc_op;
		longint    total;
		longint    mag;
		acc_word_t word;

		big = 0;
		for (int i = 0; i < `LANES; i++) begin
			if (int'(products[i].exp) > big) begin
				big = int'(products[i].exp);
			end
		end

		sum = 0;
		for (int i = 0; i < `LANES; i++) begin
			mant = int'(products[i].mant);
			if (fmt == FMT_E5M2) begin
				mant = (mant * (1 << `E5M2_PRESHIFT)) % (1 << `MANT_IN_W); // Top bits fall off
			end
			lane = longint'(mant) * 256;
			if (products[i].sign) begin
				lane = -lane;
			end
			sum += lane >>> (big - int'(products[i].exp)); // Rounds toward minus infinity
		end

		sum_exp = (big + format_bias(fmt) + int'(shared_exp) - `FP32_BIAS) & 255;

		acc_op = longint'(acc.mant) * 8;
		if (acc.exp != 0) begin
			acc_op += longint'(1) << 19; // Hidden bit
		end
		if (acc.sign) begin
			acc_op = -acc_op;
		end
		diff = int'(acc.exp) - sum_exp;

		if (diff >= `ACC_AHEAD_LIM) begin
			return acc;
		end

		if (diff >= 0 || -diff < `SUM_AHEAD_LIM) begin
			if (diff >= 0) begin
				total = sum + acc_op * (longint'(1) << diff);
				merged_exp = int'(acc.exp);
			end else begin
				total = sum * (longint'(1) << PAD_W) +
					((acc_op * (longint'(1) << PAD_W)) >>> -diff);
				merged_exp = sum_exp;
			end
			total = total & MAG_MASK; // Wraps like the 39-bit adder
			neg = total[WIDE_W-1];
			mag = neg ? ((-total) & MAG_MASK) : total;
		end else begin
			neg = (sum < 0);
			mag = (neg ? -sum : sum) * (longint'(1) << PAD_W);
			merged_exp = sum_exp;
		end

		lz = 0;
		found = 1'b0;
		for (int b = WIDE_W - 1; b >= 0; b--) begin
			if (!found && mag[b]) begin
				lz = WIDE_W - 1 - b;
				found = 1'b1;
			end
		end
		mag = (mag << (lz + 1)) & MAG_MASK;

		word.sign = neg;
		word.mant = mant_out_t'(mag >> (WIDE_W - `MANT_OUT_W));
		word.exp  = exp_t'(merged_exp - lz + 1);
		return word;
	endfunction

	initial begin
		check_count = 0;
		error_count = 0;
		cur_id      = 0;
		test_checks = 0;
		test_errors = 0;
	end

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			model_acc <= '0;
			checking  <= 1'b0;
		end else begin
			checking <= 1'b1;
			if (acc_clear) begin
				model_acc <= '0;
			end else if (valid_in) begin
				model_acc <= next_word(model_acc);
			end
		end
	end

	// Result and model both settled half a cycle after the loading edge
	always @(negedge clk) begin
		if (test_id != cur_id) begin
			if (cur_id < NUM_TESTS) begin
				$display("test %-12s %4d checks, %0d errors", test_name(cur_id),
					test_checks, test_errors);
			end
			cur_id      = test_id;
			test_checks = 0;
			test_errors = 0;
		end
		if (checking) begin
			check_count++;
			test_checks++;
			if (result !== model_acc) begin
				error_count++;
				test_errors++;
				$display("** Error %s: expected %07h, actual %07h", test_name(cur_id),
					model_acc, result);
			end
		end
	end

endmodule

/* verif/tb_fp8_dot_acc.sv */
`timescale 1ns/100ps
`include "fp8_acc_settings.svh"

module tb_fp8_dot_acc;

	import fp8_acc_pkg::*;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 2;
	localparam int NUM_TESTS    = 8;
	localparam int LEN_RESET    = 10;
	localparam int LEN_HOLD     = 16;
	localparam int LEN_FMT      = 41;
	localparam int LEN_DOM_ACC  = 19;
	localparam int LEN_DOM_SUM  = 24;
	localparam int TEST_CYCLES  = LEN_RESET + LEN_HOLD + 4 * LEN_FMT + LEN_DOM_ACC + LEN_DOM_SUM;
	localparam int LIMIT_CYCLES = RESET_CYCLES + TEST_CYCLES + 2 * NUM_TESTS + 50;

	logic        clk;
	logic        arst_n;
	logic        valid_in;
	logic        acc_clear;
	product_t    products [`LANES];
	fp_fmt_e     fmt;
	exp_t        shared_exp;
	acc_word_t   result;
	int          test_id;
	int          check_count;
	int          error_count;
	logic [15:0] lfsr_q;

	fp8_dot_acc uut (
		.clk        (clk),
		.arst_n     (arst_n),
		.valid_in   (valid_in),
		.acc_clear  (acc_clear),
		.products   (products),
		.fmt        (fmt),
		.shared_exp (shared_exp),
		.result     (result)
	);

	acc_checker #(.NUM_TESTS(NUM_TESTS)) chk (
		.clk         (clk),
		.arst_n      (arst_n),
		.valid_in    (valid_in),
		.acc_clear   (acc_clear),
		.products    (products),
		.fmt         (fmt),
		.shared_exp  (shared_exp),
		.result      (result),
		.test_id     (test_id),
		.check_count (check_count),
		.error_count (error_count)
	);

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic next_bit();
		logic fb;

		fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
		lfsr_q = {lfsr_q[14:0], fb};
		return fb;
	endfunction

	function automatic int rand_bits(int n);
		int v;

		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(next_bit());
		end
		return v;
	endfunction

	task automatic random_cycle(input logic v, input fp_fmt_e f, input int shared_lo,
		input int shared_bits, input int exp_lo, input int exp_bits);
		@(negedge clk);
		for (int i = 0; i < `LANES; i++) begin
			products[i].sign = rand_bits(1) != 0;
			products[i].exp  = exp_in_t'(exp_lo + rand_bits(exp_bits));
			products[i].mant = mant_in_t'(rand_bits(`MANT_IN_W));
		end
		fmt        = f;
		shared_exp = exp_t'(shared_lo + rand_bits(shared_bits));
		valid_in   = v;
		acc_clear  = 1'b0;
	endtask

	// Only lane 0 carries a value, so a second call with the sign flipped cancels exactly
	task automatic lane0_cycle(input logic sign, input mant_in_t mant);
		@(negedge clk);
		for (int i = 1; i < `LANES; i++) begin
			products[i] = '0;
		end
		products[0].sign = sign;
		products[0].exp  = exp_in_t'(20);
		products[0].mant = mant;
		fmt        = FMT_E4M3;
		shared_exp = exp_t'(`FP32_BIAS);
		valid_in   = 1'b1;
		acc_clear  = 1'b0;
	endtask

	task automatic clear_cycle(input logic v);
		@(negedge clk);
		valid_in  = v;
		acc_clear = 1'b1;
	endtask

	task automatic finish_test();
		@(negedge clk);
		valid_in  = 1'b0;
		acc_clear = 1'b0;
		@(posedge clk);
		test_id = test_id + 1;
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		$display("Timeout: run still going after %0d clock cycles", LIMIT_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		mant_in_t cancel_mant;

		arst_n     = 1'b0;
		valid_in   = 1'b0;
		acc_clear  = 1'b0;
		fmt        = FMT_E4M3;
		shared_exp = '0;
		test_id    = 0;
		lfsr_q     = 16'd8;
		for (int i = 0; i < `LANES; i++) begin
			products[i] = '0;
		end
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1;

		// Clear must win over valid in the same cycle
		random_cycle(1'b0, FMT_E4M3, 120, 4, 0, 4);
		repeat (6) random_cycle(1'b1, FMT_E4M3, 120, 4, 0, 4);
		clear_cycle(1'b1);
		repeat (LEN_RESET - 8) random_cycle(1'b0, FMT_E4M3, 120, 4, 0, 4);
		finish_test();

		repeat (4) random_cycle(1'b1, FMT_E3M2, 120, 4, 0, 4);
		repeat (LEN_HOLD - 4) random_cycle(1'b0, FMT_E3M2, 120, 4, 0, 4);
		finish_test();

		for (int f = 0; f < 4; f++) begin
			clear_cycle(1'b0);
			repeat (LEN_FMT - 1) random_cycle(rand_bits(2) != 0, fp_fmt_e'(f), 120, 4, 0, 4);
			finish_test();
		end

		// Large accumulator first, then tiny products far below its LSB
		clear_cycle(1'b0);
		repeat (6) random_cycle(1'b1, FMT_E4M3, 180, 0, 56, 3);
		for (int k = 0; k < LEN_DOM_ACC - 7; k++) begin
			random_cycle(k % 2 == 0, FMT_E4M3, 100, 0, 0, 3);
		end
		finish_test();

		clear_cycle(1'b0);
		random_cycle(1'b1, FMT_E4M3, 100, 0, 0, 3);
		repeat (6) random_cycle(1'b1, FMT_E4M3, 180, 0, 56, 3);
		for (int r = 0; r < (LEN_DOM_SUM - 8) / 4; r++) begin
			clear_cycle(1'b0);
			cancel_mant = mant_in_t'(rand_bits(`MANT_IN_W)) | mant_in_t'(1);
			lane0_cycle(r[0], cancel_mant);
			lane0_cycle(!r[0], cancel_mant); // Lands on zero magnitude
			random_cycle(1'b0, FMT_E4M3, 127, 0, 0, 4);
		end
		finish_test();

		@(negedge clk);
		@(posedge clk);
		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0 && check_count > 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* vlog.f */
+incdir+include
hw/fp8_acc_pkg.sv
hw/operand_align.sv
hw/product_sum.sv
hw/accum_merge.sv
hw/normalize.sv
hw/fp8_dot_acc.sv
verif/acc_checker.sv
verif/tb_fp8_dot_acc.sv
